// ==== hdl/rv32i_pkg.sv ====
package rv32i_pkg;

    typedef logic [31:0] rv32i_word;

    // major opcodes implemented by the core
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3;

    typedef enum logic [2:0] {
        f3_add  = 3'b000,  // add, sub
        f3_sll  = 3'b001,
        f3_slt  = 3'b010,
        f3_sltu = 3'b011,
        f3_xor  = 3'b100,
        f3_sr   = 3'b101,  // srl, sra
        f3_or   = 3'b110,
        f3_and  = 3'b111
    } arith_funct3;

    // immediate field widths before extension
    localparam int IMM_I_W = 12;
    localparam int IMM_S_W = 12;
    localparam int IMM_U_W = 20;

endpackage

// ==== hdl/ctrl_pkg.sv ====
package ctrl_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_ops;

    // register writeback source
    typedef enum logic [1:0] {
        wb_alu,
        wb_imm,
        wb_load
    } wb_sel;

    typedef struct packed {
        alu_ops     aluop;
        wb_sel      wbsel;
        logic       use_imm;    // operand b is the immediate
        logic       mem_read;
        logic       mem_write;
        logic [2:0] funct3;     // load / store width
        logic       reg_write;
        logic [4:0] rd;         // zero when nothing is written
    } control_word;

endpackage

// ==== hdl/inst_stream_if.sv ====
interface inst_stream_if
    import rv32i_pkg::*;
();

    logic      put;   // word valid this cycle
    rv32i_word inst;
    rv32i_word pc;
    logic      stop;  // back-pressure, or take strobe on the issue side

    modport src (
        output put, inst, pc,
        input  stop
    );

    modport dst (
        input  put, inst, pc,
        output stop
    );

endinterface

// ==== hdl/fetch_unit.sv ====
module fetch_unit
    import rv32i_pkg::*;
#(
    parameter rv32i_word RESET_PC = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          arst_n,
    output rv32i_word     inst_addr,
    output logic          inst_read,
    input  rv32i_word     inst_rdata,
    input  logic          inst_resp,
    inst_stream_if.src    fetch_q
);

    rv32i_word pc;
    logic      pending;  // one request outstanding

    // pc and request state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= RESET_PC;
            pending <= 1'b0;
        end else begin
            if (pending) begin
                if (inst_resp) begin
                    pending <= 1'b0;
                    pc      <= pc + 32'd4;
                end
            end else if (!fetch_q.stop) begin
                pending <= 1'b1;  // queue still has room for this word
            end
        end
    end

    assign inst_read = pending;
    assign inst_addr = pc;

    // returned word goes straight into the queue
    assign fetch_q.put  = pending && inst_resp;
    assign fetch_q.inst = inst_rdata;
    assign fetch_q.pc   = pc;

endmodule

// ==== hdl/inst_queue.sv ====
module inst_queue
    import rv32i_pkg::*;
#(
    parameter int unsigned QUEUE_DEPTH = 8
) (
    input  logic       clk,
    input  logic       arst_n,
    inst_stream_if.dst fetch_q,
    inst_stream_if.src issue_q
);

    localparam int AW = $clog2(QUEUE_DEPTH);
    localparam logic [AW:0] STOP_LEVEL = (AW + 1)'(QUEUE_DEPTH - 1);

    rv32i_word inst_mem [QUEUE_DEPTH];
    rv32i_word pc_mem   [QUEUE_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          push;
    logic          pop;

    assign push = fetch_q.put;
    assign pop  = issue_q.stop && (count != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (AW + 1)'(push) - (AW + 1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            inst_mem[wr_ptr] <= fetch_q.inst;
            pc_mem[wr_ptr]   <= fetch_q.pc;
        end
    end

    // head entry is visible while not empty
    assign issue_q.put  = (count != '0);
    assign issue_q.inst = inst_mem[rd_ptr];
    assign issue_q.pc   = pc_mem[rd_ptr];

    // keep one slot free for the fetch in flight
    assign fetch_q.stop = (count >= STOP_LEVEL);

endmodule

// ==== hdl/regfile.sv ====
module regfile
    import rv32i_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       we,
    input  logic [4:0] rd,
    input  rv32i_word  wdata,
    input  logic [4:0] rs1,
    input  logic [4:0] rs2,
    output rv32i_word  rs1_data,
    output rv32i_word  rs2_data
);

    rv32i_word regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != 5'd0)) begin  // x0 stays zero
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

// ==== hdl/alu.sv ====
module alu
    import rv32i_pkg::*;
    import ctrl_pkg::*;
(
    input  alu_ops    aluop,
    input  rv32i_word a,
    input  rv32i_word b,
    output rv32i_word f,
    output logic      z
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    // compare result, unsigned only for sltu
    assign z = (aluop == alu_sltu) ? (a < b) : ($signed(a) < $signed(b));

    always_comb begin
        case (aluop)
            alu_add:  f = a + b;
            alu_sub:  f = a - b;
            alu_sll:  f = a << shamt;
            alu_slt:  f = {31'b0, z};
            alu_sltu: f = {31'b0, z};
            alu_xor:  f = a ^ b;
            alu_srl:  f = a >> shamt;
            alu_sra:  f = rv32i_word'($signed(a) >>> shamt);
            alu_or:   f = a | b;
            alu_and:  f = a & b;
            default:  f = a + b;
        endcase
    end

endmodule

// ==== hdl/exec_unit.sv ====
module exec_unit
    import rv32i_pkg::*;
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    inst_stream_if.dst issue_q,
    output rv32i_word  data_addr,
    output rv32i_word  data_wdata,
    output logic [3:0] data_mbe,
    output logic       data_read,
    output logic       data_write,
    input  rv32i_word  data_rdata,
    input  logic       data_resp,
    output logic       commit_valid,
    output rv32i_word  commit_pc,
    output logic [4:0] commit_rd,
    output rv32i_word  commit_value
);

    typedef enum logic [1:0] {
        idle,
        mem_wait,
        retire
    } exec_state_e;

    exec_state_e state;
    logic        take;

    rv32i_word   inst;
    rv32i_opcode opcode;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    rv32i_word   i_imm;
    rv32i_word   s_imm;
    rv32i_word   u_imm;
    rv32i_word   imm;
    control_word ctrl;
    rv32i_word   rs1_data;
    rv32i_word   rs2_data;
    rv32i_word   alu_b;
    rv32i_word   alu_f;

    control_word ctrl_q;
    rv32i_word   pc_q;
    rv32i_word   result_q;  // alu result or effective address
    rv32i_word   imm_q;
    rv32i_word   store_q;
    rv32i_word   load_q;
    rv32i_word   rdata_sh;
    rv32i_word   load_val;
    rv32i_word   wb_value;
    logic [4:0]  byte_sh;

    function automatic alu_ops arith_op(input logic [2:0] f3, input logic alt,
                                        input logic is_reg);
        alu_ops op;
        case (arith_funct3'(f3))
            f3_add:  op = (is_reg && alt) ? alu_sub : alu_add;
            f3_sll:  op = alu_sll;
            f3_slt:  op = alu_slt;
            f3_sltu: op = alu_sltu;
            f3_xor:  op = alu_xor;
            f3_sr:   op = alt ? alu_sra : alu_srl;
            f3_or:   op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    // decode of the queue head
    assign inst   = issue_q.inst;
    assign opcode = rv32i_opcode'(inst[6:0]);
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign i_imm  = {{(32 - IMM_I_W){inst[31]}}, inst[31:20]};
    assign s_imm  = {{(32 - IMM_S_W){inst[31]}}, inst[31:25], inst[11:7]};
    assign u_imm  = {inst[31:12], {(32 - IMM_U_W){1'b0}}};

    always_comb begin
        ctrl        = '0;
        ctrl.aluop  = alu_add;
        ctrl.wbsel  = wb_alu;
        ctrl.funct3 = inst[14:12];
        imm         = i_imm;
        case (opcode)
            op_lui: begin
                imm            = u_imm;
                ctrl.wbsel     = wb_imm;
                ctrl.reg_write = 1'b1;
            end
            op_load: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.wbsel     = wb_load;
                ctrl.reg_write = 1'b1;
            end
            op_store: begin
                imm            = s_imm;
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            op_imm: begin
                ctrl.aluop     = arith_op(inst[14:12], inst[30], 1'b0);
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_reg: begin
                ctrl.aluop     = arith_op(inst[14:12], inst[30], 1'b1);
                ctrl.reg_write = 1'b1;
            end
            default: ;  // unknown opcode retires as a no-op
        endcase
        ctrl.rd = ctrl.reg_write ? inst[11:7] : 5'd0;
    end

    regfile i_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .we       ((state == retire) && ctrl_q.reg_write),
        .rd       (ctrl_q.rd),
        .wdata    (wb_value),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign alu_b = ctrl.use_imm ? imm : rs2_data;

    alu i_alu (
        .aluop (ctrl.aluop),
        .a     (rs1_data),
        .b     (alu_b),
        .f     (alu_f),
        .z     ()
    );

    // one instruction at a time, so no forwarding
    assign take         = (state == idle) && issue_q.put;
    assign issue_q.stop = take;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= idle;
            ctrl_q <= '0;
        end else begin
            case (state)
                idle: begin
                    if (take) begin
                        ctrl_q <= ctrl;
                        state  <= (ctrl.mem_read || ctrl.mem_write) ? mem_wait : retire;
                    end
                end
                mem_wait: begin
                    if (data_resp) state <= retire;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pc_q     <= issue_q.pc;
            result_q <= alu_f;
            imm_q    <= imm;
            store_q  <= rs2_data;
        end
        if ((state == mem_wait) && data_resp) load_q <= load_val;
    end

    // data port, word aligned with byte lanes
    assign byte_sh    = {result_q[1:0], 3'b000};
    assign data_addr  = {result_q[31:2], 2'b00};
    assign data_wdata = store_q << byte_sh;
    assign data_read  = (state == mem_wait) && ctrl_q.mem_read;
    assign data_write = (state == mem_wait) && ctrl_q.mem_write;

    always_comb begin
        case (store_funct3'(ctrl_q.funct3))
            sb:      data_mbe = 4'b0001 << result_q[1:0];
            sh:      data_mbe = 4'b0011 << result_q[1:0];
            sw:      data_mbe = 4'b1111;
            default: data_mbe = 4'b1111;
        endcase
    end

    // load masking and extension
    assign rdata_sh = data_rdata >> byte_sh;

    always_comb begin
        case (load_funct3'(ctrl_q.funct3))
            lb:      load_val = {{24{rdata_sh[7]}}, rdata_sh[7:0]};
            lbu:     load_val = {24'b0, rdata_sh[7:0]};
            lh:      load_val = {{16{rdata_sh[15]}}, rdata_sh[15:0]};
            lhu:     load_val = {16'b0, rdata_sh[15:0]};
            default: load_val = data_rdata;  // lw
        endcase
    end

    always_comb begin
        case (ctrl_q.wbsel)
            wb_imm:  wb_value = imm_q;
            wb_load: wb_value = load_q;
            default: wb_value = result_q;
        endcase
    end

    assign commit_valid = (state == retire);
    assign commit_pc    = pc_q;
    assign commit_rd    = ctrl_q.rd;
    assign commit_value = (ctrl_q.rd == 5'd0) ? '0 : wb_value;  // stores and x0 show zero

endmodule

// ==== hdl/rv32i_core.sv ====
module rv32i_core
    import rv32i_pkg::*;
#(
    parameter rv32i_word   RESET_PC    = 32'h0000_0000,
    parameter int unsigned QUEUE_DEPTH = 8
) (
    input  logic       clk,
    input  logic       arst_n,

    output rv32i_word  inst_addr,
    output logic       inst_read,
    input  rv32i_word  inst_rdata,
    input  logic       inst_resp,

    output rv32i_word  data_addr,
    output rv32i_word  data_wdata,
    output logic [3:0] data_mbe,
    output logic       data_read,
    output logic       data_write,
    input  rv32i_word  data_rdata,
    input  logic       data_resp,

    output logic       commit_valid,  // retirement port
    output rv32i_word  commit_pc,
    output logic [4:0] commit_rd,
    output rv32i_word  commit_value
);

    inst_stream_if fetch_q ();
    inst_stream_if issue_q ();

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) i_fetch (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_addr  (inst_addr),
        .inst_read  (inst_read),
        .inst_rdata (inst_rdata),
        .inst_resp  (inst_resp),
        .fetch_q    (fetch_q.src)
    );

    // lets fetch run ahead of execute
    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_queue (
        .clk     (clk),
        .arst_n  (arst_n),
        .fetch_q (fetch_q.dst),
        .issue_q (issue_q.src)
    );

    exec_unit i_exec (
        .clk          (clk),
        .arst_n       (arst_n),
        .issue_q      (issue_q.dst),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_mbe     (data_mbe),
        .data_read    (data_read),
        .data_write   (data_write),
        .data_rdata   (data_rdata),
        .data_resp    (data_resp),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

endmodule

// ==== verif/tb_clk_gen.sv ====
module tb_clk_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;  // free running
    end

endmodule

// ==== verif/tb_core_assert.sv ====
module tb_core_assert
    import rv32i_pkg::*;
(
    input logic       clk,
    input logic       arst_n,
    input logic       inst_read,
    input rv32i_word  inst_addr,
    input logic       inst_resp,
    input logic       data_read,
    input logic       data_write,
    input rv32i_word  data_addr,
    input rv32i_word  data_wdata,
    input logic [3:0] data_mbe,
    input logic       data_resp,
    input logic       commit_valid,
    input logic [4:0] commit_rd,
    input rv32i_word  commit_value
);
    timeunit 1ns;
    timeprecision 1ps;

    // request held with a stable address until resp
    inst_hold: assert property (@(posedge clk) disable iff (!arst_n)
        inst_read && !inst_resp |=> inst_read && $stable(inst_addr))
        else $error("instruction read dropped or address changed before resp");

    data_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (data_read || data_write) && !data_resp |=>
            $stable({data_read, data_write, data_addr, data_wdata, data_mbe}))
        else $error("data request changed before resp");

    data_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(data_read && data_write))
        else $error("data read and write high together");

    // x0 and stores retire with a zero value
    x0_value: assert property (@(posedge clk) disable iff (!arst_n)
        commit_valid && (commit_rd == 5'd0) |-> commit_value == '0)
        else $error("retirement to x0 with a nonzero value");

endmodule

bind rv32i_core tb_core_assert i_assert (.*);

// ==== verif/tb_top.sv ====
module tb_top
    import rv32i_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int        N_INST         = 200;
    localparam int        TIMEOUT_CYCLES = N_INST * 12;
    localparam rv32i_word RESET_PC       = 32'h0000_0000;

    logic       clk;
    logic       arst_n;
    rv32i_word  inst_addr;
    rv32i_word  inst_rdata;
    logic       inst_read;
    logic       inst_resp;
    rv32i_word  data_addr;
    rv32i_word  data_wdata;
    rv32i_word  data_rdata;
    logic [3:0] data_mbe;
    logic       data_read;
    logic       data_write;
    logic       data_resp;
    logic       commit_valid;
    rv32i_word  commit_pc;
    logic [4:0] commit_rd;
    rv32i_word  commit_value;

    rv32i_word   imem     [256];
    rv32i_word   dmem     [64];   // data region seen by the DUT at 0x1000
    rv32i_word   ref_mem  [64];
    rv32i_word   ref_regs [32];
    logic [15:0] lfsr;
    int          cycles;
    int          n_commit;
    rv32i_word   fetch_addr;    // next expected fetch address
    logic [1:0]  imem_wait;
    logic [1:0]  dmem_wait;
    logic        imem_busy;
    logic        dmem_busy;
    logic        d_seen_read;   // data port activity of the current instruction
    logic        d_seen_write;
    rv32i_word   d_addr;
    rv32i_word   d_wdata;
    logic [3:0]  d_mbe;

    tb_clk_gen i_clk_gen (.clk(clk));

    rv32i_core #(
        .RESET_PC    (RESET_PC),
        .QUEUE_DEPTH (4)  // small so that slow loads fill it
    ) i_dut (.*);

    // galois lfsr stepped once per bit
    function automatic rv32i_word rand_bits(input int n);
        rv32i_word r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic rv32i_word gen_inst();
        logic [2:0]  cls;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        cls = 3'(rand_bits(3));
        f3  = 3'(rand_bits(3));
        rd  = 5'(rand_bits(5));
        rs1 = 5'(rand_bits(5));
        rs2 = 5'(rand_bits(5));
        imm = 12'(rand_bits(12));
        if (rd == 5'd1) rd = 5'd0;  // x1 keeps the data base
        case (cls)
            3'd0, 3'd1: begin
                return {(f3 == 3'd0 || f3 == 3'd5) ? {1'b0, imm[0], 5'b0} : 7'b0,
                        rs2, rs1, f3, rd, op_reg};
            end
            3'd2, 3'd3: begin
                if (f3 == 3'd1) imm = {7'b0, imm[4:0]};
                if (f3 == 3'd5) imm = {1'b0, imm[10], 5'b0, imm[4:0]};  // srli or srai
                return {imm, rs1, f3, rd, op_imm};
            end
            3'd4: return {imm, rs1, f3, rd, op_lui};
            3'd5, 3'd6: begin
                if (f3 == 3'd3 || f3 > 3'd5) f3 = 3'd2;
                if (f3 == 3'd2) imm[1:0] = 2'b00;
                if (f3[0]) imm[0] = 1'b0;  // halfword aligned
                return {4'b0, imm[7:0], 5'd1, f3, rd, op_load};
            end
            default: begin
                f3 = {1'b0, f3[1:0]};
                if (f3 == 3'd3) f3 = 3'd2;
                if (f3 == 3'd2) imm[1:0] = 2'b00;
                if (f3[0]) imm[0] = 1'b0;
                return {4'b0, imm[7:5], rs2, 5'd1, f3, imm[4:0], op_store};
            end
        endcase
    endfunction

    function automatic rv32i_word ref_alu(input logic [2:0] f3, input logic alt,
                                          input rv32i_word a, input rv32i_word b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? rv32i_word'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // instruction set model stepping one instruction per call
    function automatic void ref_exec(input rv32i_word inst, output logic [4:0] rd,
                                     output rv32i_word value, output rv32i_word addr,
                                     output logic [3:0] mbe, output rv32i_word wdata);
        rv32i_word  a;
        rv32i_word  b;
        rv32i_word  ea;
        rv32i_word  sh;
        logic [2:0] f3;
        logic       alt;
        f3    = inst[14:12];
        a     = ref_regs[inst[19:15]];
        b     = ref_regs[inst[24:20]];
        alt   = inst[30] && (f3 == 3'd5 || (inst[5] && f3 == 3'd0));
        rd    = inst[11:7];
        value = '0;
        mbe   = '0;
        wdata = '0;
        ea    = '0;
        case (rv32i_opcode'(inst[6:0]))
            op_lui: value = {inst[31:12], 12'h000};
            op_imm: value = ref_alu(f3, alt, a, {{20{inst[31]}}, inst[31:20]});
            op_reg: value = ref_alu(f3, alt, a, b);
            op_load: begin
                ea = a + {{20{inst[31]}}, inst[31:20]};
                sh = ref_mem[ea[7:2]] >> {ea[1:0], 3'b000};
                case (f3)
                    3'd0:    value = {{24{sh[7]}}, sh[7:0]};
                    3'd1:    value = {{16{sh[15]}}, sh[15:0]};
                    3'd4:    value = {24'b0, sh[7:0]};
                    3'd5:    value = {16'b0, sh[15:0]};
                    default: value = sh;
                endcase
            end
            op_store: begin
                ea    = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                rd    = 5'd0;
                mbe   = (f3 == 3'd0) ? 4'b0001 : (f3 == 3'd1) ? 4'b0011 : 4'b1111;
                mbe   = mbe << ea[1:0];
                wdata = b << {ea[1:0], 3'b000};
                for (int i = 0; i < 4; i++) begin
                    if (mbe[i]) ref_mem[ea[7:2]][8*i +: 8] = wdata[8*i +: 8];
                end
            end
            default: rd = 5'd0;
        endcase
        addr = {ea[31:2], 2'b00};
        if (rd == 5'd0) value = '0;
        else ref_regs[rd] = value;
    endfunction

    function automatic rv32i_word lane_mask(input logic [3:0] mbe);
        return {{8{mbe[3]}}, {8{mbe[2]}}, {8{mbe[1]}}, {8{mbe[0]}}};
    endfunction

    task automatic check_eq(input string name, input rv32i_word expected,
                            input rv32i_word actual);
        if (expected !== actual) begin
            $display("mismatch at %0t ns: %s expected %h actual %h", $time, name,
                     expected, actual);
            $display("TEST FAIL");
            $fatal(1, "stopped at the first wrong value");
        end
    endtask

    initial begin
        lfsr         = 16'd49566;
        arst_n       = 1'b0;
        inst_rdata   = '0;
        inst_resp    = 1'b0;
        data_rdata   = '0;
        data_resp    = 1'b0;
        imem_busy    = 1'b0;
        dmem_busy    = 1'b0;
        imem_wait    = '0;
        dmem_wait    = '0;
        d_seen_read  = 1'b0;
        d_seen_write = 1'b0;
        cycles       = 0;
        n_commit     = 0;
        fetch_addr   = RESET_PC;
        for (int i = 0; i < 256; i++) begin
            imem[i] = {12'(i), 5'd0, 3'b000, 5'd0, op_imm};  // nops tagged with their index
        end
        imem[0] = {20'h00001, 5'd1, op_lui};  // x1 = 0x1000
        for (int i = 1; i < N_INST; i++) imem[i] = gen_inst();
        for (int i = 0; i < 64; i++) begin
            dmem[i]    = 32'(i + 1) * 32'h9e37_79b9;
            ref_mem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) ref_regs[i] = '0;
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
    end

    // both memories answer after 0 to 3 extra cycles
    always @(posedge clk) begin
        #1;
        if (inst_resp) begin
            inst_resp = 1'b0;
        end else if (inst_read) begin
            if (!imem_busy) begin
                imem_busy = 1'b1;
                imem_wait = 2'(rand_bits(2));
            end
            if (imem_wait == 2'd0) begin
                check_eq("inst_addr", fetch_addr, inst_addr);
                fetch_addr = fetch_addr + 32'd4;
                inst_rdata = imem[inst_addr[9:2]];
                inst_resp  = 1'b1;
                imem_busy  = 1'b0;
            end else begin
                imem_wait = imem_wait - 2'd1;
            end
        end
        if (data_resp) begin
            data_resp = 1'b0;
        end else if (data_read || data_write) begin
            if (!dmem_busy) begin
                dmem_busy = 1'b1;
                dmem_wait = 2'(rand_bits(2));
            end
            if (dmem_wait == 2'd0) begin
                d_seen_read  = data_read;
                d_seen_write = data_write;
                d_addr       = data_addr;
                d_mbe        = data_mbe;
                d_wdata      = data_wdata;
                data_rdata   = dmem[data_addr[7:2]];
                for (int i = 0; i < 4; i++) begin
                    if (data_write && data_mbe[i])
                        dmem[data_addr[7:2]][8*i +: 8] = data_wdata[8*i +: 8];
                end
                data_resp = 1'b1;
                dmem_busy = 1'b0;
            end else begin
                dmem_wait = dmem_wait - 2'd1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: only %0d instructions retired in %0d cycles", n_commit, cycles);
            $display("TEST FAIL");
            $fatal(1, "run did not finish in time");
        end
    end

    // compare each retirement against the model at mid cycle
    always @(negedge clk) begin
        rv32i_word  inst;
        rv32i_word  exp_value;
        rv32i_word  exp_addr;
        rv32i_word  exp_wdata;
        rv32i_word  lanes;
        logic [4:0] exp_rd;
        logic [3:0] exp_mbe;
        if (arst_n && commit_valid) begin
            inst = imem[n_commit];
            check_eq("commit_pc", RESET_PC + 32'(n_commit) * 32'd4, commit_pc);
            ref_exec(inst, exp_rd, exp_value, exp_addr, exp_mbe, exp_wdata);
            check_eq("commit_rd", 32'(exp_rd), 32'(commit_rd));
            check_eq("commit_value", exp_value, commit_value);
            check_eq("data_read", 32'(inst[6:0] == op_load), 32'(d_seen_read));
            check_eq("data_write", 32'(inst[6:0] == op_store), 32'(d_seen_write));
            if (inst[6:0] == op_load || inst[6:0] == op_store)
                check_eq("data_addr", exp_addr, d_addr);
            if (inst[6:0] == op_store) begin
                lanes = lane_mask(exp_mbe);  // unused lanes carry no data
                check_eq("data_mbe", 32'(exp_mbe), 32'(d_mbe));
                check_eq("data_wdata", exp_wdata & lanes, d_wdata & lanes);
            end
            d_seen_read  = 1'b0;
            d_seen_write = 1'b0;
            n_commit++;
            if (n_commit == N_INST) begin
                $display("TEST PASS");
                $finish;
            end
        end
    end

endmodule

// ==== flist.f ====
hdl/rv32i_pkg.sv
hdl/ctrl_pkg.sv
hdl/inst_stream_if.sv
hdl/fetch_unit.sv
hdl/inst_queue.sv
hdl/regfile.sv
hdl/alu.sv
hdl/exec_unit.sv
hdl/rv32i_core.sv
verif/tb_clk_gen.sv
verif/tb_core_assert.sv
verif/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_top -f flist.f -o tb_top &&
./obj_dir/tb_top || { echo "simulation failed"; exit 1; }
